// File: hdl/core_params.svh
// register map, IDs and version constants of the radio core control plane
// included by the settings, readback, PPS and routing blocks
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// settings register addresses
`define CORE_SR_MISC        8'd16
`define CORE_SR_READBACK    8'd32
`define CORE_SR_GPSDO_ST    8'd40
`define CORE_SR_PPS_SEL     8'd48

// compat and identification words
`define CORE_COMPAT_MAJOR   16'h000B
`define CORE_COMPAT_MINOR   16'h0000
`define CORE_MAGIC          32'hACE0BA5E

// stream routing
`define CORE_LOCAL_SID      8'h40
`define CORE_SID_MASK       8'hF0

// status byte, one radio in this build
`define CORE_RADIO_COUNT    8'd1

// internal PPS period in radio_clk cycles
`define CORE_PPS_PERIOD     100000000

`endif

// File: hdl/cvita_pkg.sv
// packet format types for the control and response streams
// import in any block that handles stream beats
`default_nettype none

package cvita_pkg;

    // first beat of every packet
    typedef struct packed {
        logic [15:0] seqnum;
        logic [15:0] length;
        logic [15:0] src_sid;
        logic [15:0] dst_sid;
    } cvita_hdr_t;

    // second beat of a command packet
    typedef struct packed {
        logic [23:0] reserved;
        logic [7:0]  addr;
        logic [31:0] data;
    } cvita_cmd_t;

    // one data word, decoded by position in the packet
    typedef union packed {
        cvita_hdr_t hdr;
        cvita_cmd_t cmd;
    } cvita_beat_u;

    // stream beat, ready travels back separately
    typedef struct packed {
        cvita_beat_u tdata;
        logic        tlast;
        logic        tvalid;
    } axis_beat_t;

endpackage

`default_nettype wire

// File: hdl/core_regs_pkg.sv
// register side types: settings bus and the select encodings
// import in blocks that drive or decode settings
`default_nettype none

package core_regs_pkg;

    // single-cycle write strobe with address and data
    typedef struct packed {
        logic        stb;
        logic [7:0]  addr;
        logic [31:0] data;
    } set_bus_t;

    // readback word select
    typedef enum logic [1:0] {
        RB_COMPAT   = 2'd0,
        RB_RESERVED = 2'd1,
        RB_STATUS   = 2'd2,
        RB_LOCK     = 2'd3
    } rb_sel_e;

    // PPS source select
    typedef enum logic [1:0] {
        PPS_GPSDO = 2'd0,
        PPS_EXT   = 2'd1,
        PPS_INT   = 2'd2,
        PPS_OFF   = 2'd3
    } pps_sel_e;

endpackage

`default_nettype wire

// File: hdl/ctrl_router.sv
// steers each control packet to the local processor or the forward port
// decision taken on the header beat, no added latency
`default_nettype none
`timescale 1ns/10ps

`include "core_params.svh"

module ctrl_router
    import cvita_pkg::*;
(
    input  wire        radio_clk,
    input  wire        bus_rst,
    input  axis_beat_t i_ctrl,
    output logic       o_ctrl_ready,
    output axis_beat_t o_local,
    input  wire        i_local_ready,
    output axis_beat_t o_fwd_ctrl,
    input  wire        i_fwd_ready
);

    logic r_first;
    logic r_local;
    logic id_match;
    logic sel_local;
    logic xfer;

    // masked compare of the low byte of the destination
    assign id_match  = (i_ctrl.tdata.hdr.dst_sid[7:0] & `CORE_SID_MASK) == `CORE_LOCAL_SID;
    assign sel_local = r_first ? id_match : r_local;

    //////////////////////////////////////////////////
    // steering
    //////////////////////////////////////////////////
    always_comb begin
        o_local           = i_ctrl;
        o_fwd_ctrl        = i_ctrl;
        o_local.tvalid    = i_ctrl.tvalid && sel_local;
        o_fwd_ctrl.tvalid = i_ctrl.tvalid && !sel_local;
        o_ctrl_ready      = sel_local ? i_local_ready : i_fwd_ready;
    end

    assign xfer = i_ctrl.tvalid && o_ctrl_ready;

    // hold the destination until tlast
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            r_first <= 1'b1;
            r_local <= 1'b0;
        end else if (xfer) begin
            if (i_ctrl.tlast) begin
                r_first <= 1'b1;
            end else if (r_first) begin
                r_first <= 1'b0;
                r_local <= id_match;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/core_ctrl_proc.sv
// local control processor: decodes header plus command, issues one settings
// write and answers with a header and the readback word
`default_nettype none
`timescale 1ns/10ps

module core_ctrl_proc
    import cvita_pkg::*;
    import core_regs_pkg::*;
(
    input  wire         radio_clk,
    input  wire         bus_rst,
    input  axis_beat_t  i_ctrl,
    output logic        o_ctrl_ready,
    output axis_beat_t  o_resp,
    input  wire         i_resp_ready,
    output set_bus_t    o_set,
    input  wire  [63:0] i_rb_data
);

    typedef enum logic [2:0] {
        ST_HDR,
        ST_CMD,
        ST_WRITE,
        ST_RESP_HDR,
        ST_RESP_PAY,
        ST_DRAIN
    } state_e;

    state_e      r_state;
    cvita_hdr_t  r_hdr;
    cvita_hdr_t  resp_hdr;
    logic        r_more;
    logic        r_set_stb;
    logic [7:0]  r_set_addr;
    logic [31:0] r_set_data;
    logic [63:0] r_rb;
    logic        ctrl_xfer;
    logic        resp_xfer;

    assign o_ctrl_ready = (r_state == ST_HDR) || (r_state == ST_CMD) || (r_state == ST_DRAIN);
    assign ctrl_xfer    = i_ctrl.tvalid && o_ctrl_ready;
    assign resp_xfer    = o_resp.tvalid && i_resp_ready;

    assign o_set = '{stb: r_set_stb, addr: r_set_addr, data: r_set_data};

    //////////////////////////////////////////////////
    // packet FSM
    //////////////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            r_state   <= ST_HDR;
            r_more    <= 1'b0;
            r_set_stb <= 1'b0;
        end else begin
            r_set_stb <= 1'b0;
            case (r_state)
                // header with tlast has no command, drop it
                ST_HDR: if (ctrl_xfer && !i_ctrl.tlast) r_state <= ST_CMD;
                ST_CMD: begin
                    if (ctrl_xfer) begin
                        r_set_stb <= 1'b1;
                        r_more    <= !i_ctrl.tlast;
                        r_state   <= ST_WRITE;
                    end
                end
                ST_WRITE: r_state <= ST_RESP_HDR;
                ST_RESP_HDR: if (resp_xfer) r_state <= ST_RESP_PAY;
                ST_RESP_PAY: if (resp_xfer) r_state <= r_more ? ST_DRAIN : ST_HDR;
                // extra beats after the command
                ST_DRAIN: if (ctrl_xfer && i_ctrl.tlast) r_state <= ST_HDR;
                default: r_state <= ST_HDR;
            endcase
        end
    end

    // header, command fields and readback sample
    always_ff @(posedge radio_clk) begin
        if (r_state == ST_HDR && ctrl_xfer) begin
            r_hdr <= i_ctrl.tdata.hdr;
        end
        if (r_state == ST_CMD && ctrl_xfer) begin
            r_set_addr <= i_ctrl.tdata.cmd.addr;
            r_set_data <= i_ctrl.tdata.cmd.data;
        end
        // taken after the write, so a select change shows up here
        if (r_state == ST_RESP_HDR && resp_xfer) begin
            r_rb <= i_rb_data;
        end
    end

    //////////////////////////////////////////////////
    // response beats
    //////////////////////////////////////////////////
    always_comb begin
        resp_hdr = '{seqnum:  r_hdr.seqnum,
                     length:  r_hdr.length,
                     src_sid: r_hdr.dst_sid,
                     dst_sid: r_hdr.src_sid};
        o_resp.tvalid = (r_state == ST_RESP_HDR) || (r_state == ST_RESP_PAY);
        o_resp.tlast  = (r_state == ST_RESP_PAY);
        if (r_state == ST_RESP_PAY) begin
            o_resp.tdata = cvita_beat_u'(r_rb);
        end else begin
            o_resp.tdata.hdr = resp_hdr;
        end
    end

endmodule

`default_nettype wire

// File: hdl/settings_bank.sv
// core settings registers, each loaded on a strobe at its own address
`default_nettype none
`timescale 1ns/10ps

`include "core_params.svh"

module settings_bank
    import core_regs_pkg::*;
(
    input  wire         radio_clk,
    input  wire         bus_rst,
    input  set_bus_t    i_set,
    output logic [31:0] o_misc_outs,
    output rb_sel_e     o_rb_sel,
    output logic [7:0]  o_gpsdo_st,
    output pps_sel_e    o_pps_sel
);

    logic wr_misc;
    logic wr_rb_sel;
    logic wr_gpsdo;
    logic wr_pps_sel;

    // address decode
    assign wr_misc    = i_set.stb && (i_set.addr == `CORE_SR_MISC);
    assign wr_rb_sel  = i_set.stb && (i_set.addr == `CORE_SR_READBACK);
    assign wr_gpsdo   = i_set.stb && (i_set.addr == `CORE_SR_GPSDO_ST);
    assign wr_pps_sel = i_set.stb && (i_set.addr == `CORE_SR_PPS_SEL);

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            o_misc_outs <= 32'd0;
            o_rb_sel    <= RB_COMPAT;
            o_pps_sel   <= PPS_GPSDO;
        end else begin
            if (wr_misc) o_misc_outs <= i_set.data;
            if (wr_rb_sel) o_rb_sel <= rb_sel_e'(i_set.data[1:0]);
            if (wr_pps_sel) o_pps_sel <= pps_sel_e'(i_set.data[1:0]);
        end
    end

    // gpsdo status survives a core reset
    always_ff @(posedge radio_clk) begin
        if (wr_gpsdo) o_gpsdo_st <= i_set.data[7:0];
    end

endmodule

`default_nettype wire

// File: hdl/readback_mux.sv
// readback word for the control processor, lock bits synchronized first
`default_nettype none
`timescale 1ns/10ps

`include "core_params.svh"

module readback_mux
    import core_regs_pkg::*;
(
    input  wire         radio_clk,
    input  wire         bus_rst,
    input  rb_sel_e     i_rb_sel,
    input  wire  [7:0]  i_gpsdo_st,
    input  wire  [31:0] i_rb_misc,
    input  wire  [1:0]  i_lock,
    output logic [63:0] o_rb_data
);

    logic [1:0] r_lock_meta;
    logic [1:0] r_lock;

    // front-end lock bits, two stages
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            r_lock_meta <= 2'b00;
            r_lock      <= 2'b00;
        end else begin
            r_lock_meta <= i_lock;
            r_lock      <= r_lock_meta;
        end
    end

    always_comb begin
        case (i_rb_sel)
            RB_COMPAT: o_rb_data = {`CORE_MAGIC, `CORE_COMPAT_MAJOR, `CORE_COMPAT_MINOR};
            RB_STATUS: o_rb_data = {16'h0, `CORE_RADIO_COUNT, i_gpsdo_st, i_rb_misc};
            RB_LOCK:   o_rb_data = {62'h0, r_lock};
            // spi readback slot, no spi core here
            default:   o_rb_data = 64'h0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/pps_select.sv
// PPS source selection: gpsdo, external or internal divider
// every source goes through the same two-flop synchronizer
`default_nettype none
`timescale 1ns/10ps

`include "core_params.svh"

module pps_select
    import core_regs_pkg::*;
#(
    parameter int PPS_PERIOD = `CORE_PPS_PERIOD
) (
    input  wire      radio_clk,
    input  wire      bus_rst,
    input  wire      i_pps_gpsdo,
    input  wire      i_pps_ext,
    input  pps_sel_e i_pps_sel,
    output logic     o_pps
);

    localparam int CNT_W = $clog2(PPS_PERIOD);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PPS_PERIOD - 1);

    logic [CNT_W-1:0] r_cnt;
    logic             r_int_pps;
    logic [1:0]       r_gpsdo_del;
    logic [1:0]       r_ext_del;
    logic [1:0]       r_int_del;

    //////////////////////////////////////////////////
    // internal divider and synchronizers
    //////////////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            r_cnt       <= '0;
            r_int_pps   <= 1'b0;
            r_gpsdo_del <= 2'b00;
            r_ext_del   <= 2'b00;
            r_int_del   <= 2'b00;
        end else begin
            r_cnt       <= (r_cnt == CNT_LAST) ? '0 : r_cnt + 1'b1;
            // one cycle high per period
            r_int_pps   <= (r_cnt == CNT_LAST);
            r_gpsdo_del <= {r_gpsdo_del[0], i_pps_gpsdo};
            r_ext_del   <= {r_ext_del[0], i_pps_ext};
            r_int_del   <= {r_int_del[0], r_int_pps};
        end
    end

    always_comb begin
        case (i_pps_sel)
            PPS_GPSDO: o_pps = r_gpsdo_del[1];
            PPS_EXT:   o_pps = r_ext_del[1];
            PPS_INT:   o_pps = r_int_del[1];
            default:   o_pps = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/resp_arbiter.sv
// two-input packet arbiter for the response stream
// round robin between packets with the grant held until tlast
`default_nettype none
`timescale 1ns/10ps

module resp_arbiter
    import cvita_pkg::*;
(
    input  wire        radio_clk,
    input  wire        bus_rst,
    input  axis_beat_t i_local,
    output logic       o_local_ready,
    input  axis_beat_t i_fwd,
    output logic       o_fwd_ready,
    output axis_beat_t o_resp,
    input  wire        i_resp_ready
);

    logic r_busy;
    logic r_grant;
    logic r_prio;
    logic pick;
    logic sel;
    logic xfer;

    // r_prio names the favoured input while no packet is open
    always_comb begin
        if (r_prio) begin
            pick = i_fwd.tvalid ? 1'b1 : !i_local.tvalid;
        end else begin
            pick = i_local.tvalid ? 1'b0 : i_fwd.tvalid;
        end
    end

    assign sel           = r_busy ? r_grant : pick;
    assign o_resp        = sel ? i_fwd : i_local;
    assign o_local_ready = !sel && i_resp_ready;
    assign o_fwd_ready   = sel && i_resp_ready;
    assign xfer          = o_resp.tvalid && i_resp_ready;

    //////////////////////////////////////////////////
    // packet lock and pointer
    //////////////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            r_busy  <= 1'b0;
            r_grant <= 1'b0;
            r_prio  <= 1'b0;
        end else if (xfer && o_resp.tlast) begin
            r_busy <= 1'b0;
            r_prio <= !sel;
        end else if (o_resp.tvalid) begin
            // a presented beat keeps its source until the packet ends
            r_busy  <= 1'b1;
            r_grant <= sel;
        end
    end

endmodule

`default_nettype wire

// File: hdl/radio_core.sv
// control plane of the radio core: routing, control processor,
// settings, readback, PPS select and response merge
`default_nettype none
`timescale 1ns/10ps

`include "core_params.svh"

module radio_core
    import cvita_pkg::*;
    import core_regs_pkg::*;
#(
    parameter int PPS_PERIOD = `CORE_PPS_PERIOD
) (
    input  wire         radio_clk,
    input  wire         bus_rst,
    input  axis_beat_t  i_ctrl,
    output logic        o_ctrl_ready,
    output axis_beat_t  o_resp,
    input  wire         i_resp_ready,
    output axis_beat_t  o_fwd_ctrl,
    input  wire         i_fwd_ready,
    input  axis_beat_t  i_fwd_resp,
    output logic        o_fwd_resp_ready,
    input  wire  [31:0] i_rb_misc,
    input  wire  [1:0]  i_lock,
    input  wire         i_pps_gpsdo,
    input  wire         i_pps_ext,
    output logic        o_pps,
    output logic [31:0] o_misc_outs
);

    axis_beat_t  local_ctrl;
    logic        local_ctrl_ready;
    axis_beat_t  local_resp;
    logic        local_resp_ready;
    set_bus_t    set_bus;
    rb_sel_e     rb_sel;
    pps_sel_e    pps_sel;
    logic [7:0]  gpsdo_st;
    logic [63:0] rb_data;

    ctrl_router u_ctrl_router (
        .radio_clk     (radio_clk),
        .bus_rst       (bus_rst),
        .i_ctrl        (i_ctrl),
        .o_ctrl_ready  (o_ctrl_ready),
        .o_local       (local_ctrl),
        .i_local_ready (local_ctrl_ready),
        .o_fwd_ctrl    (o_fwd_ctrl),
        .i_fwd_ready   (i_fwd_ready)
    );

    core_ctrl_proc u_core_ctrl_proc (
        .radio_clk    (radio_clk),
        .bus_rst      (bus_rst),
        .i_ctrl       (local_ctrl),
        .o_ctrl_ready (local_ctrl_ready),
        .o_resp       (local_resp),
        .i_resp_ready (local_resp_ready),
        .o_set        (set_bus),
        .i_rb_data    (rb_data)
    );

    settings_bank u_settings_bank (
        .radio_clk   (radio_clk),
        .bus_rst     (bus_rst),
        .i_set       (set_bus),
        .o_misc_outs (o_misc_outs),
        .o_rb_sel    (rb_sel),
        .o_gpsdo_st  (gpsdo_st),
        .o_pps_sel   (pps_sel)
    );

    readback_mux u_readback_mux (
        .radio_clk  (radio_clk),
        .bus_rst    (bus_rst),
        .i_rb_sel   (rb_sel),
        .i_gpsdo_st (gpsdo_st),
        .i_rb_misc  (i_rb_misc),
        .i_lock     (i_lock),
        .o_rb_data  (rb_data)
    );

    pps_select #(
        .PPS_PERIOD (PPS_PERIOD)
    ) u_pps_select (
        .radio_clk   (radio_clk),
        .bus_rst     (bus_rst),
        .i_pps_gpsdo (i_pps_gpsdo),
        .i_pps_ext   (i_pps_ext),
        .i_pps_sel   (pps_sel),
        .o_pps       (o_pps)
    );

    // local responses on input 0, radio responses on input 1
    resp_arbiter u_resp_arbiter (
        .radio_clk     (radio_clk),
        .bus_rst       (bus_rst),
        .i_local       (local_resp),
        .o_local_ready (local_resp_ready),
        .i_fwd         (i_fwd_resp),
        .o_fwd_ready   (o_fwd_resp_ready),
        .o_resp        (o_resp),
        .i_resp_ready  (i_resp_ready)
    );

endmodule

`default_nettype wire

// File: testbench/tb_radio_core.sv
// testbench for the radio core control plane
// drives command and forwarded packets and checks responses with assertions
`default_nettype none
`timescale 1ns/10ps

`include "core_params.svh"

module tb_radio_core
    import cvita_pkg::*;
();

    localparam int          WAIT_LIMIT  = 400;
    localparam logic [15:0] HOST_SID    = 16'h0C20;
    localparam logic [15:0] LOCAL_DST   = 16'h0041;
    localparam logic [15:0] RADIO_SID   = 16'h0C10;
    localparam logic [15:0] PKT_LEN     = 16'h0010;
    localparam logic [31:0] RB_MISC     = 32'hC0FFEE01;
    localparam logic [63:0] COMPAT_WORD = {`CORE_MAGIC, `CORE_COMPAT_MAJOR, `CORE_COMPAT_MINOR};

    logic        radio_clk;
    logic        bus_rst;
    axis_beat_t  i_ctrl;
    logic        o_ctrl_ready;
    axis_beat_t  o_resp;
    logic        i_resp_ready;
    axis_beat_t  o_fwd_ctrl;
    logic        i_fwd_ready;
    axis_beat_t  i_fwd_resp;
    logic        o_fwd_resp_ready;
    logic [31:0] i_rb_misc;
    logic [1:0]  i_lock;
    logic        i_pps_gpsdo;
    logic        i_pps_ext;
    logic        o_pps;
    logic [31:0] o_misc_outs;

    int          errors;
    int          timeouts;
    integer      seed;
    int          cyc;
    logic        stall_on;
    logic        pps_off_chk;
    logic        pps_int_chk;
    logic [63:0] resp_data_q[$];
    logic        resp_last_q[$];
    logic [63:0] fwd_data_q[$];
    logic        fwd_last_q[$];
    int          resp_pkts_seen;
    int          resp_pkts_taken;
    logic [63:0] pkt_beats[0:7];
    int          pkt_len;
    int          exp_local_seq;
    int          exp_fwd_k;
    logic [63:0] exp_local_pay;

    radio_core #(
        .PPS_PERIOD (50)
    ) u_radio_core (
        .radio_clk        (radio_clk),
        .bus_rst          (bus_rst),
        .i_ctrl           (i_ctrl),
        .o_ctrl_ready     (o_ctrl_ready),
        .o_resp           (o_resp),
        .i_resp_ready     (i_resp_ready),
        .o_fwd_ctrl       (o_fwd_ctrl),
        .i_fwd_ready      (i_fwd_ready),
        .i_fwd_resp       (i_fwd_resp),
        .o_fwd_resp_ready (o_fwd_resp_ready),
        .i_rb_misc        (i_rb_misc),
        .i_lock           (i_lock),
        .i_pps_gpsdo      (i_pps_gpsdo),
        .i_pps_ext        (i_pps_ext),
        .o_pps            (o_pps),
        .o_misc_outs      (o_misc_outs)
    );

    initial begin
        radio_clk = 1'b0;
        forever #20 radio_clk = ~radio_clk;
    end

    always @(posedge radio_clk) begin
        cyc++;
    end

    // ready stalls on the response and forward ports
    always @(posedge radio_clk) begin
        #2;
        if (stall_on) begin
            i_resp_ready = ($random(seed) & 3) != 0;
            i_fwd_ready  = ($random(seed) & 3) != 0;
        end else begin
            i_resp_ready = 1'b1;
            i_fwd_ready  = 1'b1;
        end
    end

    // output monitors sampled mid-cycle
    always @(negedge radio_clk) begin
        if (!bus_rst && o_resp.tvalid && i_resp_ready) begin
            resp_data_q.push_back(o_resp.tdata);
            resp_last_q.push_back(o_resp.tlast);
            if (o_resp.tlast) resp_pkts_seen++;
        end
        if (!bus_rst && o_fwd_ctrl.tvalid && i_fwd_ready) begin
            fwd_data_q.push_back(o_fwd_ctrl.tdata);
            fwd_last_q.push_back(o_fwd_ctrl.tlast);
        end
    end

    //////////////////////////////////////////////////
    // concurrent checks
    //////////////////////////////////////////////////
    assert property (@(posedge radio_clk) disable iff (bus_rst)
        o_resp.tvalid && !i_resp_ready |=> o_resp.tvalid && $stable(o_resp.tdata))
    else begin
        errors++;
        $display("response beat changed or dropped while stalled");
    end

    assert property (@(posedge radio_clk) disable iff (bus_rst)
        o_fwd_ctrl.tvalid && !i_fwd_ready |=> o_fwd_ctrl.tvalid && $stable(o_fwd_ctrl.tdata))
    else begin
        errors++;
        $display("forwarded control beat changed or dropped while stalled");
    end

    assert property (@(posedge radio_clk) pps_off_chk |-> !o_pps)
    else begin
        errors++;
        $display("o_pps high while the PPS source is off");
    end

    assert property (@(posedge radio_clk) pps_int_chk && o_pps |=> !o_pps)
    else begin
        errors++;
        $display("internal PPS pulse longer than one cycle");
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    task automatic tick();
        @(posedge radio_clk);
        #2;
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [63:0] make_hdr(input logic [15:0] seq, input logic [15:0] len,
                                             input logic [15:0] src, input logic [15:0] dst);
        return {seq, len, src, dst};
    endfunction

    function automatic logic [63:0] make_cmd(input logic [7:0] addr, input logic [31:0] data);
        return {24'h0, addr, data};
    endfunction

    // beat i of forwarded radio response number k
    function automatic logic [63:0] fwd_word(input int k, input int i);
        if (i == 0) begin
            return make_hdr(16'(k), 16'h0018, RADIO_SID, 16'h0002);
        end
        return {16'hF00D, 16'(k), 32'(i)};
    endfunction

    task automatic send_beat(input logic to_fwd, input logic [63:0] data, input logic last);
        int   cnt;
        logic done;
        cnt  = 0;
        done = 1'b0;
        if (to_fwd) begin
            i_fwd_resp.tdata  = data;
            i_fwd_resp.tlast  = last;
            i_fwd_resp.tvalid = 1'b1;
        end else begin
            i_ctrl.tdata  = data;
            i_ctrl.tlast  = last;
            i_ctrl.tvalid = 1'b1;
        end
        while (!done && cnt < WAIT_LIMIT) begin
            @(negedge radio_clk);
            done = to_fwd ? o_fwd_resp_ready : o_ctrl_ready;
            tick();
            cnt++;
        end
        if (!done) begin
            if (to_fwd) note_timeout("a forwarded response beat to be accepted");
            else note_timeout("a control beat to be accepted");
        end
        if (to_fwd) i_fwd_resp.tvalid = 1'b0;
        else i_ctrl.tvalid = 1'b0;
    endtask

    task automatic send_cmd(input logic [15:0] seq, input logic [7:0] addr,
                            input logic [31:0] data);
        send_beat(1'b0, make_hdr(seq, PKT_LEN, HOST_SID, LOCAL_DST), 1'b0);
        send_beat(1'b0, make_cmd(addr, data), 1'b1);
    endtask

    task automatic send_fwd_pkt(input int k);
        for (int i = 0; i < 3; i++) begin
            send_beat(1'b1, fwd_word(k, i), i == 2);
        end
    endtask

    // pops one complete packet from the o_resp monitor
    task automatic take_packet();
        int   cnt;
        logic done;
        cnt     = 0;
        done    = 1'b0;
        pkt_len = 0;
        while (resp_pkts_seen == resp_pkts_taken && cnt < WAIT_LIMIT) begin
            tick();
            cnt++;
        end
        if (resp_pkts_seen == resp_pkts_taken) begin
            note_timeout("a response packet on o_resp");
        end else begin
            resp_pkts_taken++;
            while (!done && pkt_len < 8 && resp_data_q.size() > 0) begin
                pkt_beats[pkt_len] = resp_data_q.pop_front();
                done = resp_last_q.pop_front();
                pkt_len++;
            end
        end
    endtask

    task automatic check_local_pkt(input logic [15:0] seq, input logic [63:0] pay);
        check_value("response length", pkt_len, 2);
        check_value("o_resp header", pkt_beats[0], make_hdr(seq, PKT_LEN, LOCAL_DST, HOST_SID));
        check_value("o_resp payload", pkt_beats[1], pay);
    endtask

    task automatic check_fwd_pkt(input int k);
        check_value("forwarded response length", pkt_len, 3);
        for (int i = 0; i < 3; i++) begin
            check_value("o_resp forwarded beat", pkt_beats[i], fwd_word(k, i));
        end
    endtask

    // sorts a packet by source and checks each source in its own order
    task automatic take_and_sort();
        take_packet();
        if (pkt_len > 0 && pkt_beats[0][31:16] == RADIO_SID) begin
            check_fwd_pkt(exp_fwd_k);
            exp_fwd_k++;
        end else begin
            check_local_pkt(16'(exp_local_seq), exp_local_pay);
            exp_local_seq++;
        end
    endtask

    task automatic do_write(input logic [15:0] seq, input logic [7:0] addr,
                            input logic [31:0] data, input logic [63:0] pay);
        send_cmd(seq, addr, data);
        take_packet();
        check_local_pkt(seq, pay);
    endtask

    task automatic check_fwd_beat(input logic [63:0] exp, input logic exp_last);
        int          cnt;
        logic [63:0] got;
        logic        got_last;
        cnt = 0;
        while (fwd_data_q.size() == 0 && cnt < WAIT_LIMIT) begin
            tick();
            cnt++;
        end
        if (fwd_data_q.size() == 0) begin
            note_timeout("a beat on o_fwd_ctrl");
        end else begin
            got      = fwd_data_q.pop_front();
            got_last = fwd_last_q.pop_front();
            check_value("o_fwd_ctrl.tdata", got, exp);
            check_value("o_fwd_ctrl.tlast", got_last, exp_last);
        end
    endtask

    // three-beat non-local packet, checked beat by beat on o_fwd_ctrl
    task automatic forward_ctrl_pkt(input logic [15:0] seq);
        logic [63:0] w[0:2];
        w[0] = make_hdr(seq, 16'h0018, HOST_SID, 16'h0031);
        w[1] = {16'h1111, seq, 32'h33334444};
        w[2] = {16'h5555, seq, 32'h77778888};
        for (int i = 0; i < 3; i++) begin
            send_beat(1'b0, w[i], i == 2);
        end
        for (int i = 0; i < 3; i++) begin
            check_fwd_beat(w[i], i == 2);
        end
    endtask

    // cycle number of the next rising PPS edge
    task automatic wait_pps_pulse(output int at);
        int   cnt;
        logic seen_low;
        logic found;
        cnt      = 0;
        seen_low = 1'b0;
        found    = 1'b0;
        while (!found && cnt < WAIT_LIMIT) begin
            @(negedge radio_clk);
            if (!o_pps) seen_low = 1'b1;
            else if (seen_low) found = 1'b1;
            cnt++;
        end
        at = cyc;
        if (!found) note_timeout("an internal PPS pulse");
        tick();
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        logic [2:0] ext_hist;
        logic       v;
        int         t0;
        int         t1;

        errors          = 0;
        timeouts        = 0;
        seed            = 89248;
        cyc             = 0;
        stall_on        = 1'b0;
        pps_off_chk     = 1'b0;
        pps_int_chk     = 1'b0;
        resp_pkts_seen  = 0;
        resp_pkts_taken = 0;
        bus_rst         = 1'b1;
        i_ctrl          = '0;
        i_fwd_resp      = '0;
        i_resp_ready    = 1'b1;
        i_fwd_ready     = 1'b1;
        i_rb_misc       = RB_MISC;
        i_lock          = 2'b00;
        i_pps_gpsdo     = 1'b0;
        i_pps_ext       = 1'b0;
        repeat (8) @(posedge radio_clk);
        #2;
        bus_rst = 1'b0;

        // reset state and compat readback
        @(negedge radio_clk);
        check_value("o_resp.tvalid", o_resp.tvalid, 1'b0);
        check_value("o_fwd_ctrl.tvalid", o_fwd_ctrl.tvalid, 1'b0);
        check_value("o_pps", o_pps, 1'b0);
        check_value("o_misc_outs", o_misc_outs, 32'h0);
        tick();
        do_write(16'h0001, 8'h00, 32'h0, COMPAT_WORD);

        // misc register and header echo
        do_write(16'h0002, `CORE_SR_MISC, 32'h5A5A1234, COMPAT_WORD);
        check_value("o_misc_outs", o_misc_outs, 32'h5A5A1234);

        // readback selects
        do_write(16'h0010, `CORE_SR_GPSDO_ST, 32'h000000A7, COMPAT_WORD);
        do_write(16'h0011, `CORE_SR_READBACK, 32'd2,
                 {16'h0, `CORE_RADIO_COUNT, 8'hA7, RB_MISC});
        i_lock = 2'b10;
        repeat (5) tick();
        do_write(16'h0012, `CORE_SR_READBACK, 32'd3, {62'h0, 2'b10});
        do_write(16'h0013, `CORE_SR_READBACK, 32'd1, 64'h0);
        do_write(16'h0014, `CORE_SR_READBACK, 32'd0, COMPAT_WORD);

        // non-local packet goes out unchanged
        forward_ctrl_pkt(16'h0077);

        // radio responses merged with local ones
        exp_local_pay = COMPAT_WORD;
        exp_fwd_k     = 0;
        exp_local_seq = 16'h0030;
        send_fwd_pkt(0);
        take_and_sort();
        fork
            begin
                repeat (3) tick();
                send_fwd_pkt(1);
            end
            send_cmd(16'h0030, 8'h00, 32'h0);
        join
        take_and_sort();
        take_and_sort();

        // random back-pressure on both outputs
        stall_on      = 1'b1;
        exp_local_seq = 16'h0040;
        fork
            for (int i = 0; i < 6; i++) begin
                send_cmd(16'(16'h0040 + i), `CORE_SR_MISC, 32'h10000000 + i);
            end
            for (int k = 2; k < 5; k++) begin
                send_fwd_pkt(k);
            end
        join
        for (int n = 0; n < 9; n++) begin
            take_and_sort();
        end
        for (int k = 0; k < 4; k++) begin
            forward_ctrl_pkt(16'(16'h0078 + k));
        end
        stall_on = 1'b0;
        repeat (4) tick();
        check_value("local responses", exp_local_seq, 16'h0046);
        check_value("forwarded responses", exp_fwd_k, 5);
        check_value("unclaimed packets", resp_pkts_seen - resp_pkts_taken, 0);
        check_value("o_misc_outs", o_misc_outs, 32'h10000005);

        // external PPS two cycles behind the input
        do_write(16'h0060, `CORE_SR_PPS_SEL, 32'd1, COMPAT_WORD);
        ext_hist = 3'b000;
        for (int k = 0; k < 24; k++) begin
            v         = $random(seed) & 1;
            i_pps_ext = v;
            ext_hist  = {ext_hist[1:0], v};
            @(negedge radio_clk);
            check_value("o_pps", o_pps, ext_hist[2]);
            tick();
        end

        // internal divider
        do_write(16'h0061, `CORE_SR_PPS_SEL, 32'd2, COMPAT_WORD);
        pps_int_chk = 1'b1;
        wait_pps_pulse(t0);
        wait_pps_pulse(t1);
        check_value("internal PPS spacing", t1 - t0, 50);
        pps_int_chk = 1'b0;

        // PPS off while both inputs toggle
        do_write(16'h0062, `CORE_SR_PPS_SEL, 32'd3, COMPAT_WORD);
        pps_off_chk = 1'b1;
        for (int k = 0; k < 60; k++) begin
            i_pps_ext   = $random(seed) & 1;
            i_pps_gpsdo = $random(seed) & 1;
            tick();
        end
        pps_off_chk = 1'b0;

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+hdl
hdl/cvita_pkg.sv
hdl/core_regs_pkg.sv
hdl/ctrl_router.sv
hdl/core_ctrl_proc.sv
hdl/settings_bank.sv
hdl/readback_mux.sv
hdl/pps_select.sv
hdl/resp_arbiter.sv
hdl/radio_core.sv
testbench/tb_radio_core.sv

// File: Bender.yml
package:
  name: radio_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cvita_pkg.sv
      - hdl/core_regs_pkg.sv
      - hdl/ctrl_router.sv
      - hdl/core_ctrl_proc.sv
      - hdl/settings_bank.sv
      - hdl/readback_mux.sv
      - hdl/pps_select.sv
      - hdl/resp_arbiter.sv
      - hdl/radio_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_radio_core.sv
